//--- nocPkg.sv
`default_nettype none

package nocPkg;

  // **************************************************
  // Router sizes.
  // **************************************************
  localparam int numPorts = 5;
  localparam int queueDepth = 4;
  localparam int ptrWidth = $clog2(queueDepth);

  // **************************************************
  // Flit fields.
  // **************************************************
  typedef logic [2:0] flitIdT;
  typedef logic [11:0] lengthT;    // Slice limit in clock periods.
  typedef logic [15:0] payloadT;
  typedef logic [2:0] portIdT;     // 0 L, 1 N, 2 E, 3 W, 4 S.
  typedef logic [numPorts-1:0] portMaskT;

  localparam flitIdT flitHead = 3'b001;
  localparam flitIdT flitBody = 3'b010;
  localparam flitIdT flitTail = 3'b100;

  typedef struct packed {
    flitIdT flitId;
    lengthT length;                // Only meaningful in head flits.
    payloadT payload;
  } flitT;

  // **************************************************
  // Arbiter states.
  // **************************************************
  typedef enum logic [2:0] {
    idle   = 3'd0,
    grantL = 3'd1,
    grantN = 3'd2,
    grantE = 3'd3,
    grantW = 3'd4,
    grantS = 3'd5                  // Grant state n serves port n-1.
  } arbStateT;

endpackage

`default_nettype wire

//--- flitTimer.sv
`timescale 1ns/1ps
`default_nettype none

module flitTimer (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flitT  headFlit,
  input  logic          headValid,
  input  logic          run,
  output logic          timesUp
);

  import nocPkg::*;

  lengthT limit;
  lengthT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headValid && headFlit.flitId == flitHead)
        limit <= headFlit.length;   // New packet sets the slice.
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;                // Cleared whenever the grant lapses.
    end
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

//--- inputQueue.sv
`timescale 1ns/1ps
`default_nettype none

module inputQueue (
  input  logic          clk,
  input  logic          rst,
  input  logic          inValid,
  output logic          inReady,
  input  nocPkg::flitT  inFlit,
  input  logic          pop,
  output nocPkg::flitT  headFlit,
  output logic          notEmpty
);

  import nocPkg::*;

  flitT mem [queueDepth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0] count;
  logic push;

  function automatic logic [ptrWidth-1:0] advance(logic [ptrWidth-1:0] p);
    if (p == ptrWidth'(queueDepth - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign inReady = (count != (ptrWidth + 1)'(queueDepth));
  assign notEmpty = (count != '0);
  assign push = inValid && inReady;
  assign headFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= advance(wrPtr);
      if (pop)
        rdPtr <= advance(rdPtr);
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;                  // Both or neither, occupancy holds.
      endcase
    end
  end

  // Output stage must never pop a drained queue.
  popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> notEmpty)
    else $error("inputQueue pop while empty");

endmodule

`default_nettype wire

//--- portArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module portArbiter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  nocPkg::portMaskT                       req,
  input  nocPkg::flitT [nocPkg::numPorts-1:0]    headFlit,
  output nocPkg::portMaskT                       grant
);

  import nocPkg::*;

  arbStateT state;
  arbStateT nextState;
  portIdT curPort;
  portMaskT inState;
  portMaskT run;
  portMaskT timesUp;

  // Nearest requester after cur, wrapping back to cur last.
  function automatic arbStateT rotate(portIdT cur, portMaskT r);
    arbStateT s;
    int idx;
    s = idle;
    for (int k = numPorts; k >= 1; k--)
    begin
      idx = (int'(cur) + k) % numPorts;
      if (r[idx])
        s = arbStateT'(idx + 1);
    end
    return s;
  endfunction

  // **************************************************
  // Time-slice timers.
  // **************************************************
  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    flitTimer timer (
      .clk       (clk),
      .rst       (rst),
      .headFlit  (headFlit[i]),
      .headValid (req[i]),
      .run       (run[i]),
      .timesUp   (timesUp[i])
    );
  end

  // **************************************************
  // Grant FSM.
  // **************************************************
  assign curPort = portIdT'(state) - 3'd1;
  assign inState = (state == idle) ? '0 : portMaskT'(1) << curPort;
  assign grant = inState & req;
  assign run = inState & req & ~timesUp;   // High only on edges that stay.

  always_comb
  begin
    if (state == idle)
      nextState = rotate(portIdT'(numPorts - 1), req);   // Fixed order from L.
    else if (|run)
      nextState = state;
    else
      nextState = rotate(curPort, req);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= nextState;
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("portArbiter grant not one-hot");

endmodule

`default_nettype wire

//--- linkOutputStage.sv
`timescale 1ns/1ps
`default_nettype none

module linkOutputStage (
  input  logic                                   clk,
  input  logic                                   rst,
  input  nocPkg::portMaskT                       grant,
  input  nocPkg::flitT [nocPkg::numPorts-1:0]    headFlit,
  output nocPkg::portMaskT                       pop,
  output logic                                   outValid,
  input  logic                                   outReady,
  output nocPkg::flitT                           outFlit,
  output nocPkg::portIdT                         outSrc
);

  import nocPkg::*;

  flitT selFlit;
  portIdT selSrc;
  logic regFree;

  always_comb
  begin
    selFlit = '0;
    selSrc = '0;
    for (int i = 0; i < numPorts; i++)
      if (grant[i])
      begin
        selFlit = headFlit[i];
        selSrc = portIdT'(i);       // Tag for the receiver.
      end
  end

  assign regFree = !outValid || outReady;   // Empty or draining now.
  assign pop = regFree ? grant : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (regFree)
      outValid <= |grant;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= selFlit;
      outSrc <= selSrc;
    end
  end

  // Held flit stays put until the link takes it.
  outHold: assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outFlit) && $stable(outSrc))
    else $error("linkOutputStage output changed under back-pressure");

endmodule

`default_nettype wire

//--- routerOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort (
  input  logic                                   clk,
  input  logic                                   rst,
  input  nocPkg::portMaskT                       inValid,
  output nocPkg::portMaskT                       inReady,
  input  nocPkg::flitT [nocPkg::numPorts-1:0]    inFlit,
  output logic                                   outValid,
  input  logic                                   outReady,
  output nocPkg::flitT                           outFlit,
  output nocPkg::portIdT                         outSrc
);

  import nocPkg::*;

  flitT [numPorts-1:0] headFlit;
  portMaskT notEmpty;
  portMaskT grant;
  portMaskT pop;

  // **************************************************
  // Input queues, one per port.
  // **************************************************
  for (genvar i = 0; i < numPorts; i++)
  begin : gQueue
    inputQueue queue (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[i]),
      .inReady  (inReady[i]),
      .inFlit   (inFlit[i]),
      .pop      (pop[i]),
      .headFlit (headFlit[i]),
      .notEmpty (notEmpty[i])
    );
  end

  // **************************************************
  // Arbitration and link drive.
  // **************************************************
  portArbiter portArb (
    .clk      (clk),
    .rst      (rst),
    .req      (notEmpty),
    .headFlit (headFlit),
    .grant    (grant)
  );

  linkOutputStage outStage (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .headFlit (headFlit),
    .pop      (pop),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit),
    .outSrc   (outSrc)
  );

endmodule

`default_nettype wire

//--- tbRouterOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

module tbRouterOutputPort;

  import nocPkg::*;

  localparam int sliceLength = 3;
  localparam int maxRun = sliceLength + 1;
  localparam int flitsPerPkt = 5;
  localparam int satCycles = 300;
  localparam int randCycles = 600;
  localparam int waitLimit = 1000;

  logic clk;
  logic rst;
  portMaskT inValid;
  portMaskT inReady;
  flitT [numPorts-1:0] inFlit;
  logic outValid;
  logic outReady;
  flitT outFlit;
  portIdT outSrc;

  int seed;
  int valueErrors;
  int otherErrors;
  int waitCount;
  int seqNum [numPorts];
  flitT refQ [numPorts][$];      // Flits sent, oldest first.
  logic saturated;
  logic idleWatch;

  // Falling-edge monitor results.
  logic flitBad;
  logic strayBad;
  logic holdBad;
  logic runBad;
  logic rotBad;
  logic idleBad;
  flitT gotFlit;
  flitT expFlit;
  portIdT gotSrc;
  portIdT lastSrc;
  portIdT rotExp;
  int runLen;
  logic holdPrev;
  flitT heldFlit;
  portIdT heldSrc;
  flitT holdExpFlit;
  portIdT holdExpSrc;

  routerOutputPort u_dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit),
    .outSrc   (outSrc)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Payload carries source port and sequence number.
  function automatic flitT makeFlit(int port, int seq);
    flitT f;
    int pos;
    pos = seq % flitsPerPkt;
    f.payload = {portIdT'(port), 13'(seq)};
    f.length = '0;
    if (pos == 0)
    begin
      f.flitId = flitHead;
      f.length = lengthT'(sliceLength);
    end
    else if (pos == flitsPerPkt - 1)
      f.flitId = flitTail;
    else
      f.flitId = flitBody;
    return f;
  endfunction

  function automatic portIdT nextPort(portIdT p);
    if (p == portIdT'(numPorts - 1))
      return '0;
    return p + 3'd1;
  endfunction

  function automatic int pendingFlits();
    int n;
    n = 0;
    for (int i = 0; i < numPorts; i++)
      n = n + refQ[i].size();
    return n;
  endfunction

  // An offered flit stays on its port until it is taken.
  task automatic stepCycle(input portMaskT offer, input logic ready);
    portMaskT nextValid;
    flitT [numPorts-1:0] nextFlit;
    @(posedge clk);
    for (int i = 0; i < numPorts; i++)
    begin
      if (inValid[i] && inReady[i])
        seqNum[i] = seqNum[i] + 1;
      nextValid[i] = (inValid[i] && !inReady[i]) || offer[i];
      nextFlit[i] = makeFlit(i, seqNum[i]);
    end
    inValid <= nextValid;
    inFlit <= nextFlit;
    outReady <= ready;
  endtask

  // **************************************************
  // Monitor samples where everything is settled.
  // **************************************************
  always @(negedge clk)
  begin
    flitBad = 1'b0;
    strayBad = 1'b0;
    runBad = 1'b0;
    rotBad = 1'b0;
    holdBad = 1'b0;
    idleBad = 1'b0;
    if (rst)
    begin
      holdPrev = 1'b0;
      runLen = 0;
    end
    else
    begin
      for (int i = 0; i < numPorts; i++)
        if (inValid[i] && inReady[i])
          refQ[i].push_back(inFlit[i]);
      holdBad = holdPrev && (!outValid || outFlit != heldFlit || outSrc != heldSrc);
      holdExpFlit = heldFlit;
      holdExpSrc = heldSrc;
      heldFlit = outFlit;
      heldSrc = outSrc;
      holdPrev = outValid && !outReady;
      idleBad = idleWatch && outValid;
      if (outValid && outReady)
      begin
        gotFlit = outFlit;
        gotSrc = outSrc;
        if (int'(outSrc) >= numPorts || refQ[outSrc].size() == 0)
          strayBad = 1'b1;
        else
        begin
          expFlit = refQ[outSrc].pop_front();
          flitBad = (gotFlit != expFlit);
        end
        if (runLen > 0 && outSrc == lastSrc)
          runLen++;
        else
        begin
          rotExp = nextPort(lastSrc);
          rotBad = saturated && runLen > 0 && outSrc != rotExp;
          runLen = 1;
        end
        runBad = saturated && runLen > maxRun;
        lastSrc = outSrc;
      end
    end
  end

  flitOrder: assert property (@(posedge clk) disable iff (rst) !flitBad)
    else
    begin
      valueErrors++;
      $display("CHECK FAILED outFlit port %h got %h expected %h", gotSrc, gotFlit, expFlit);
    end

  flitKnown: assert property (@(posedge clk) disable iff (rst) !strayBad)
    else
    begin
      otherErrors++;
      $display("Output flit from port %0d arrived with nothing outstanding.", gotSrc);
    end

  outputHold: assert property (@(posedge clk) disable iff (rst) !holdBad)
    else
    begin
      valueErrors++;
      $display("CHECK FAILED outFlit/outSrc under back-pressure got %h/%h expected %h/%h",
        heldFlit, heldSrc, holdExpFlit, holdExpSrc);
    end

  sliceLimit: assert property (@(posedge clk) disable iff (rst) !runBad)
    else
    begin
      valueErrors++;
      $display("CHECK FAILED run length port %h got %h limit %h", gotSrc, runLen, maxRun);
    end

  rotation: assert property (@(posedge clk) disable iff (rst) !rotBad)
    else
    begin
      valueErrors++;
      $display("CHECK FAILED outSrc after run got %h expected %h", gotSrc, rotExp);
    end

  quietLink: assert property (@(posedge clk) disable iff (rst) !idleBad)
    else
    begin
      valueErrors++;
      $display("CHECK FAILED outValid after drain got %h expected %h", 1'b1, 1'b0);
    end

  // **************************************************
  // Stimulus.
  // **************************************************
  initial
  begin
    seed = 32'he719;
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    outReady = 1'b0;
    valueErrors = 0;
    otherErrors = 0;
    saturated = 1'b0;
    idleWatch = 1'b0;
    for (int i = 0; i < numPorts; i++)
      seqNum[i] = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!outValid)
      else
      begin
        valueErrors++;
        $display("CHECK FAILED outValid after reset got %h expected %h", outValid, 1'b0);
      end
    assert (inReady == '1)
      else
      begin
        valueErrors++;
        $display("CHECK FAILED inReady after reset got %h expected %h", inReady, 5'h1f);
      end

    for (int c = 0; c < satCycles; c++)
    begin
      if (c == 20)
        saturated = 1'b1;             // All queues full by now.
      stepCycle('1, 1'b1);
    end
    saturated = 1'b0;

    for (int c = 0; c < randCycles; c++)
      stepCycle(portMaskT'($random(seed)), ($random(seed) & 3) != 0);

    waitCount = 0;
    do
    begin
      stepCycle('0, 1'b1);
      waitCount++;
    end while (inValid != '0 && waitCount < waitLimit);
    if (inValid != '0)
    begin
      otherErrors++;
      $display("Timeout while waiting for the input ports to accept their last flits.");
    end

    waitCount = 0;
    do
    begin
      @(posedge clk);
      waitCount++;
    end while ((outValid || pendingFlits() != 0) && waitCount < waitLimit);
    if (outValid || pendingFlits() != 0)
    begin
      otherErrors++;
      $display("Timeout while waiting for %0d flits to leave the link.", pendingFlits());
    end

    idleWatch = 1'b1;
    repeat (20) @(posedge clk);       // Link must stay quiet.
    for (int i = 0; i < numPorts; i++)
      assert (refQ[i].size() == 0)
        else
        begin
          valueErrors++;
          $display("CHECK FAILED refQ[%0d] size got %h expected %h", i, refQ[i].size(), 0);
        end

    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- routerOutputPort.f
nocPkg.sv
flitTimer.sv
inputQueue.sv
portArbiter.sv
linkOutputStage.sv
routerOutputPort.sv
tbRouterOutputPort.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tbRouterOutputPort
FILELIST ?= routerOutputPort.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Test failures found
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation finished, see $(LOG)"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
